// ==== rtl/lsu_params.svh ====
`ifndef LSU_PARAMS_SVH
`define LSU_PARAMS_SVH

// Data path widths
`define LSU_DATA_W 32
`define LSU_ADDR_W 8    // 256 words
`define LSU_TAG_W 4

// Store queue size, power of two
`define LSU_STQ_DEPTH 4

`endif

// ==== rtl/lsu_req_pkg.sv ====
`include "lsu_params.svh"

package lsu_req_pkg;

    // ------------------------------
    // Opcode
    // ------------------------------
    typedef enum logic {
        OP_LOAD  = 1'b0,
        OP_STORE = 1'b1
    } op_e;

    // Dispatch request, 45 bits
    typedef struct packed {
        op_e                    op;
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] data;    // Store data only
        logic [`LSU_TAG_W-1:0]  tag;
    } req_t;

endpackage

// ==== rtl/lsu_res_pkg.sv ====
`include "lsu_params.svh"

package lsu_res_pkg;

    // Load response, 36 bits
    typedef struct packed {
        logic [`LSU_TAG_W-1:0]  tag;
        logic [`LSU_DATA_W-1:0] data;
    } resp_t;

    // ------------------------------
    // Store queue search
    // ------------------------------
    typedef struct packed {
        logic                   valid;
        logic [`LSU_ADDR_W-1:0] addr;
    } fwd_req_t;

    typedef struct packed {
        logic                   hit;
        logic [`LSU_DATA_W-1:0] data;    // Youngest matching store
    } fwd_res_t;

endpackage

// ==== rtl/lsu_dcache.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_dcache (
    input  logic                   i_clk,
    input  logic                   i_rst_n,

    input  logic                   i_rd_en,
    input  logic [`LSU_ADDR_W-1:0] i_rd_addr,
    output logic [`LSU_DATA_W-1:0] o_rd_data,

    input  logic                   i_wr_en,
    input  logic [`LSU_ADDR_W-1:0] i_wr_addr,
    input  logic [`LSU_DATA_W-1:0] i_wr_data
);

    localparam int WORDS = 1 << `LSU_ADDR_W;

    logic [`LSU_DATA_W-1:0] r_mem [WORDS];

    // Write port, array starts zeroed
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            for (int i = 0; i < WORDS; i++) begin
                r_mem[i] <= '0;
            end
        end else if (i_wr_en) begin
            r_mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Registered read, old word on same-address write
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_rd_data <= '0;
        end else if (i_rd_en) begin
            o_rd_data <= r_mem[i_rd_addr];   // Held until next read
        end
    end

endmodule

// ==== rtl/lsu_stq.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_stq (
    input  logic                   i_clk,
    input  logic                   i_rst_n,

    input  logic                   i_push_valid,
    input  lsu_req_pkg::req_t      i_push,
    output logic                   o_push_ready,

    input  lsu_res_pkg::fwd_req_t  i_fwd_req,
    output lsu_res_pkg::fwd_res_t  o_fwd_res,

    input  logic                   i_commit,

    output logic                   o_drain_valid,
    output logic [`LSU_ADDR_W-1:0] o_drain_addr,
    output logic [`LSU_DATA_W-1:0] o_drain_data
);

    localparam int IDX_W = $clog2(`LSU_STQ_DEPTH);

    logic [`LSU_ADDR_W-1:0] r_addr [`LSU_STQ_DEPTH];
    logic [`LSU_DATA_W-1:0] r_data [`LSU_STQ_DEPTH];

    logic [IDX_W-1:0]       r_head;     // Oldest entry
    logic [IDX_W-1:0]       r_tail;     // Next free slot
    logic [IDX_W:0]         r_count;
    logic [IDX_W:0]         r_cmt_cnt;  // Committed, not yet drained

    logic                   w_push;
    logic                   w_drain;
    logic                   w_commit;

    assign o_push_ready = r_count != (IDX_W+1)'(`LSU_STQ_DEPTH);
    assign w_push       = i_push_valid && o_push_ready;
    assign w_drain      = r_cmt_cnt != '0;
    assign w_commit     = i_commit && (r_cmt_cnt < r_count);  // Saturates

    assign o_drain_valid = w_drain;
    assign o_drain_addr  = r_addr[r_head];
    assign o_drain_data  = r_data[r_head];

    // ------------------------------
    // Youngest-match search
    // ------------------------------
    always_comb begin : search
        logic [IDX_W-1:0]       idx;
        logic                   hit;
        logic [`LSU_DATA_W-1:0] data;
        hit  = 1'b0;
        data = '0;
        idx  = '0;
        // Walk back from the tail, first hit is the youngest
        for (int k = 0; k < `LSU_STQ_DEPTH; k++) begin
            idx = r_tail - IDX_W'(k + 1);
            if (i_fwd_req.valid && !hit && ((IDX_W+1)'(k) < r_count) &&
                (r_addr[idx] == i_fwd_req.addr)) begin
                hit  = 1'b1;
                data = r_data[idx];
            end
        end
        o_fwd_res.hit  = hit;
        o_fwd_res.data = data;
    end

    // ------------------------------
    // Pointers and counts
    // ------------------------------
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_head    <= '0;
            r_tail    <= '0;
            r_count   <= '0;
            r_cmt_cnt <= '0;
        end else begin
            if (w_push) begin
                r_tail <= r_tail + 1'b1;
            end
            if (w_drain) begin
                r_head <= r_head + 1'b1;
            end
            r_count   <= r_count + (IDX_W+1)'(w_push) - (IDX_W+1)'(w_drain);
            r_cmt_cnt <= r_cmt_cnt + (IDX_W+1)'(w_commit) - (IDX_W+1)'(w_drain);
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_push) begin
            r_addr[r_tail] <= i_push.addr;
            r_data[r_tail] <= i_push.data;
        end
    end

endmodule

// ==== rtl/lsu_pipe.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_pipe (
    input  logic                   i_clk,
    input  logic                   i_rst_n,

    input  logic                   i_req_valid,
    input  lsu_req_pkg::req_t      i_req,
    output logic                   o_req_ready,

    output logic                   o_stq_push_valid,
    output lsu_req_pkg::req_t      o_stq_push,
    input  logic                   i_stq_push_ready,

    output lsu_res_pkg::fwd_req_t  o_fwd_req,
    input  lsu_res_pkg::fwd_res_t  i_fwd_res,

    output logic                   o_rd_en,
    output logic [`LSU_ADDR_W-1:0] o_rd_addr,
    input  logic [`LSU_DATA_W-1:0] i_rd_data,

    output logic                   o_resp_valid,
    output lsu_res_pkg::resp_t     o_resp,
    input  logic                   i_resp_ready
);

    logic                   w_is_store;
    logic                   w_ex2_free;
    logic                   w_ex1_move;
    logic                   w_ex1_open;
    logic                   w_load_take;

    logic                   r_ex1_valid;
    logic [`LSU_ADDR_W-1:0] r_ex1_addr;
    logic [`LSU_TAG_W-1:0]  r_ex1_tag;

    logic                   r_ex2_valid;
    logic [`LSU_TAG_W-1:0]  r_ex2_tag;
    logic                   r_ex2_fwd_hit;
    logic [`LSU_DATA_W-1:0] r_ex2_fwd_data;

    // ------------------------------
    // Stall and accept
    // ------------------------------
    assign w_is_store  = i_req.op == lsu_req_pkg::OP_STORE;
    assign w_ex2_free  = !r_ex2_valid || i_resp_ready;    // Empty or leaving
    assign w_ex1_move  = r_ex1_valid && w_ex2_free;
    assign w_ex1_open  = !r_ex1_valid || w_ex1_move;

    // Stores also wait on ex1 so that age order holds
    assign o_req_ready = w_ex1_open && (!w_is_store || i_stq_push_ready);
    assign w_load_take = i_req_valid && o_req_ready && !w_is_store;

    assign o_stq_push_valid = i_req_valid && w_ex1_open && w_is_store;
    assign o_stq_push       = i_req;

    // ex1 lookups
    assign o_fwd_req.valid = r_ex1_valid;
    assign o_fwd_req.addr  = r_ex1_addr;
    assign o_rd_en         = w_ex1_move;    // Read only on the move into ex2
    assign o_rd_addr       = r_ex1_addr;

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            r_ex1_valid <= 1'b0;
            r_ex2_valid <= 1'b0;
        end else begin
            if (w_load_take) begin
                r_ex1_valid <= 1'b1;
            end else if (w_ex1_move) begin
                r_ex1_valid <= 1'b0;
            end
            if (w_ex1_move) begin
                r_ex2_valid <= 1'b1;
            end else if (i_resp_ready) begin
                r_ex2_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (w_load_take) begin
            r_ex1_addr <= i_req.addr;
            r_ex1_tag  <= i_req.tag;
        end
        if (w_ex1_move) begin
            r_ex2_tag      <= r_ex1_tag;
            r_ex2_fwd_hit  <= i_fwd_res.hit;
            r_ex2_fwd_data <= i_fwd_res.data;
        end
    end

    // ------------------------------
    // ex2 response
    // ------------------------------
    assign o_resp_valid = r_ex2_valid;
    assign o_resp.tag   = r_ex2_tag;
    assign o_resp.data  = r_ex2_fwd_hit ? r_ex2_fwd_data : i_rd_data;

endmodule

// ==== rtl/lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module lsu_top (
    input  logic               i_clk,
    input  logic               i_rst_n,

    input  logic               i_req_valid,
    input  lsu_req_pkg::req_t  i_req,
    output logic               o_req_ready,

    output logic               o_resp_valid,
    output lsu_res_pkg::resp_t o_resp,
    input  logic               i_resp_ready,

    input  logic               i_commit
);

    logic                   w_stq_push_valid;
    lsu_req_pkg::req_t      w_stq_push;
    logic                   w_stq_push_ready;
    lsu_res_pkg::fwd_req_t  w_fwd_req;
    lsu_res_pkg::fwd_res_t  w_fwd_res;

    logic                   w_drain_valid;
    logic [`LSU_ADDR_W-1:0] w_drain_addr;
    logic [`LSU_DATA_W-1:0] w_drain_data;

    logic                   w_rd_en;
    logic [`LSU_ADDR_W-1:0] w_rd_addr;
    logic [`LSU_DATA_W-1:0] w_rd_data;

    // ------------------------------
    // Pipe
    // ------------------------------
    lsu_pipe u_pipe (
        .i_clk            (i_clk           ),
        .i_rst_n          (i_rst_n         ),
        .i_req_valid      (i_req_valid     ),
        .i_req            (i_req           ),
        .o_req_ready      (o_req_ready     ),
        .o_stq_push_valid (w_stq_push_valid),
        .o_stq_push       (w_stq_push      ),
        .i_stq_push_ready (w_stq_push_ready),
        .o_fwd_req        (w_fwd_req       ),
        .i_fwd_res        (w_fwd_res       ),
        .o_rd_en          (w_rd_en         ),
        .o_rd_addr        (w_rd_addr       ),
        .i_rd_data        (w_rd_data       ),
        .o_resp_valid     (o_resp_valid    ),
        .o_resp           (o_resp          ),
        .i_resp_ready     (i_resp_ready    )
    );

    // Store queue, drains into the array
    lsu_stq u_stq (
        .i_clk         (i_clk           ),
        .i_rst_n       (i_rst_n         ),
        .i_push_valid  (w_stq_push_valid),
        .i_push        (w_stq_push      ),
        .o_push_ready  (w_stq_push_ready),
        .i_fwd_req     (w_fwd_req       ),
        .o_fwd_res     (w_fwd_res       ),
        .i_commit      (i_commit        ),
        .o_drain_valid (w_drain_valid   ),
        .o_drain_addr  (w_drain_addr    ),
        .o_drain_data  (w_drain_data    )
    );

    lsu_dcache u_dcache (
        .i_clk     (i_clk        ),
        .i_rst_n   (i_rst_n      ),
        .i_rd_en   (w_rd_en      ),
        .i_rd_addr (w_rd_addr    ),
        .o_rd_data (w_rd_data    ),
        .i_wr_en   (w_drain_valid),
        .i_wr_addr (w_drain_addr ),
        .i_wr_data (w_drain_data )
    );

endmodule

// ==== test/tb_lsu_top.sv ====
`timescale 1ns/1ps
`include "lsu_params.svh"

module tb_lsu_top;

    // One line of the input file
    typedef struct packed {
        logic [7:0]             test;
        logic [1:0]             op;         // 0 load, 1 store, 2 idle
        logic [`LSU_ADDR_W-1:0] addr;
        logic [`LSU_DATA_W-1:0] data;
        logic                   commit;
        logic [`LSU_DATA_W-1:0] exp;
    } line_t;

    logic                  i_clk;
    logic                  i_rst_n;
    logic                  i_req_valid;
    lsu_req_pkg::req_t     i_req;
    logic                  o_req_ready;
    logic                  o_resp_valid;
    lsu_res_pkg::resp_t    o_resp;
    logic                  i_resp_ready;
    logic                  i_commit;

    line_t                 lines[$];
    lsu_res_pkg::resp_t    exp_q[$];    // Outstanding loads, issue order
    lsu_res_pkg::resp_t    exp_head;
    logic [`LSU_TAG_W-1:0] next_tag;
    logic [7:0]            cur_test;
    logic                  commit_pend;
    logic [31:0]           lcg_state;
    int                    pass_cnt;
    int                    fail_cnt;
    int                    test_errs;
    int                    cycles;
    int                    cycle_limit;

    lsu_top u_dut (
        .i_clk        (i_clk       ),
        .i_rst_n      (i_rst_n     ),
        .i_req_valid  (i_req_valid ),
        .i_req        (i_req       ),
        .o_req_ready  (o_req_ready ),
        .o_resp_valid (o_resp_valid),
        .o_resp       (o_resp      ),
        .i_resp_ready (i_resp_ready),
        .i_commit     (i_commit    )
    );

    initial begin
        i_clk = 1'b0;
        forever #4 i_clk = ~i_clk;
    end

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    // Ready drops on about one cycle in four
    always @(negedge i_clk) begin
        if (i_rst_n) begin
            lcg_state    = lcg_next(lcg_state);
            i_resp_ready = lcg_state[31:30] != 2'b00;
        end
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            $display("Fail %s: got 0x%h, expected 0x%h", name, got, exp);
            fail_cnt++;
            test_errs++;
        end else begin
            pass_cnt++;
        end
    endtask

    // ------------------------------
    // Response monitor
    // ------------------------------
    always @(posedge i_clk) begin
        if (i_rst_n && o_resp_valid && i_resp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Error: response with tag 0x%h but no load outstanding", o_resp.tag);
                fail_cnt++;
                test_errs++;
            end else begin
                exp_head = exp_q.pop_front();
                check_value("o_resp.tag", 32'(o_resp.tag), 32'(exp_head.tag));
                check_value("o_resp.data", o_resp.data, exp_head.data);
            end
        end
    end

    task automatic read_input();
        int          fd;
        int          n;
        int          t;
        int          op;
        int          cm;
        logic [31:0] ad;
        logic [31:0] da;
        logic [31:0] ex;
        string       text;
        line_t       ln;
        fd = $fopen("test/lsu_input.txt", "r");
        if (fd == 0) begin
            $display("Error: cannot open the input file test/lsu_input.txt");
            return;
        end
        while ($fgets(text, fd) != 0) begin
            if (text.len() < 2 || text[0] == "#") continue;   // Header or blank
            n = $sscanf(text, "%d %d %h %h %d %h", t, op, ad, da, cm, ex);
            if (n != 6) begin
                $display("Error: malformed input line: %s", text);
                fail_cnt++;
            end else begin
                ln.test   = t[7:0];
                ln.op     = op[1:0];
                ln.addr   = ad[`LSU_ADDR_W-1:0];
                ln.data   = da;
                ln.commit = cm[0];
                ln.exp    = ex;
                lines.push_back(ln);
            end
        end
        $fclose(fd);
    endtask

    // One cycle with no request, pending commit goes out
    task automatic idle_cycle();
        @(negedge i_clk);
        i_req_valid = 1'b0;
        i_commit    = commit_pend;
        commit_pend = 1'b0;
    endtask

    task automatic send_line(input line_t ln);
        lsu_res_pkg::resp_t item;
        if (ln.op == 2'd2) begin
            idle_cycle();
        end else begin
            @(negedge i_clk);
            i_commit    = commit_pend;
            commit_pend = 1'b0;
            i_req_valid = 1'b1;
            i_req.op    = (ln.op == 2'd1) ? lsu_req_pkg::OP_STORE : lsu_req_pkg::OP_LOAD;
            i_req.addr  = ln.addr;
            i_req.data  = ln.data;
            i_req.tag   = next_tag;
            @(posedge i_clk);
            while (!o_req_ready) begin   // Hold until taken
                @(negedge i_clk);
                i_commit = 1'b0;
                @(posedge i_clk);
            end
            if (ln.op == 2'd0) begin
                item.tag  = next_tag;
                item.data = ln.exp;
                exp_q.push_back(item);
            end
            next_tag++;
        end
        commit_pend = ln.commit;
    endtask

    task automatic finish_test(input logic [7:0] num);
        idle_cycle();
        while (exp_q.size() != 0) idle_cycle();
        $display("Test %0d finished: %0d mismatches", num, test_errs);
        test_errs = 0;
    endtask

    // ------------------------------
    // Watchdog
    // ------------------------------
    initial begin
        cycles      = 0;
        cycle_limit = 0;
        wait (cycle_limit != 0);
        while (cycles < cycle_limit) begin
            @(posedge i_clk);
            cycles++;
        end
        $display("Timeout: run did not finish within %0d cycles", cycle_limit);
        $display("TEST FAILED");
        $finish;
    end

    initial begin
        i_rst_n      = 1'b0;
        i_req_valid  = 1'b0;
        i_req        = '0;
        i_resp_ready = 1'b1;
        i_commit     = 1'b0;
        commit_pend  = 1'b0;
        next_tag     = '0;
        lcg_state    = 32'hcb6ce8e3;
        pass_cnt     = 0;
        fail_cnt     = 0;
        test_errs    = 0;
        read_input();
        if (lines.size() == 0) begin
            $display("Error: no operations were read, nothing to run");
            fail_cnt++;
        end else begin
            cycle_limit = 40 * lines.size();
            repeat (3) @(posedge i_clk);
            @(negedge i_clk);
            i_rst_n  = 1'b1;
            cur_test = lines[0].test;
            foreach (lines[i]) begin
                if (lines[i].test != cur_test) begin
                    finish_test(cur_test);
                    cur_test = lines[i].test;
                end
                send_line(lines[i]);
            end
            finish_test(cur_test);
            repeat (8) idle_cycle();    // Catch duplicate responses
        end
        $display("Checks passed: %0d, failed: %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// ==== test/lsu_input.txt ====
# test op(0 load, 1 store, 2 idle) addr(hex) data(hex) commit expected(hex)
# commit 1 pulses i_commit once the line's request is taken; expected is used by loads only
1 0 10 00000000 0 00000000
1 0 20 00000000 0 00000000
1 0 ff 00000000 0 00000000
2 1 30 11111111 0 00000000
2 0 30 00000000 0 11111111
2 1 30 22222222 0 00000000
2 0 30 00000000 0 22222222
2 0 31 00000000 0 00000000
3 1 40 a0a0a0a0 1 00000000
3 1 41 b1b1b1b1 1 00000000
3 2 00 00000000 1 00000000
3 2 00 00000000 1 00000000
3 2 00 00000000 0 00000000
3 2 00 00000000 0 00000000
3 0 30 00000000 0 22222222
3 0 40 00000000 0 a0a0a0a0
3 0 41 00000000 0 b1b1b1b1
3 0 42 00000000 0 00000000
4 1 50 c0000001 0 00000000
4 1 51 c0000002 0 00000000
4 1 52 c0000003 0 00000000
4 1 53 c0000004 1 00000000
4 1 54 c0000005 0 00000000
4 0 54 00000000 0 c0000005
4 0 50 00000000 0 c0000001
4 0 53 00000000 0 c0000004
5 0 51 00000000 0 c0000002
5 0 52 00000000 0 c0000003
5 0 40 00000000 0 a0a0a0a0
5 0 54 00000000 0 c0000005
5 0 10 00000000 0 00000000
5 0 30 00000000 0 22222222

// ==== verilog.f ====
+incdir+rtl
rtl/lsu_req_pkg.sv
rtl/lsu_res_pkg.sv
rtl/lsu_dcache.sv
rtl/lsu_stq.sv
rtl/lsu_pipe.sv
rtl/lsu_top.sv
test/tb_lsu_top.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build the LSU testbench with Verilator and run it
set -e

cd "$(dirname "$0")"
rm -rf obj_dir sim.log

verilator --binary --timing -Wno-fatal -f verilog.f --top-module tb_lsu_top

./obj_dir/Vtb_lsu_top > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
    exit 1
fi
if ! grep -q "TEST OK" sim.log; then
    echo "Simulation ended without a result line"
    exit 1
fi
